// ==== src/timer_pkg.sv ====
package timer_pkg;

  localparam int num_counters = 3;   // counters 0..2
  localparam int count_w      = 16;  // binary count width
  localparam int ctrl_sel_w   = 2;   // select field of the control word
  localparam int reg_sel_w    = 2;   // {wb_adr_i, wb_sel_i[1]}

  // control word layout: sel[7:6] rw[5:4] mode[3:1] bcd[0]
  localparam int cw_sel_msb  = 7;
  localparam int cw_rw_msb   = 5;
  localparam int cw_mode_msb = 3;

  localparam logic [reg_sel_w-1:0] reg_sel_ctrl = 2'b11;  // control word, high lane

  typedef enum logic [2:0] {
    mode_rate   = 3'd2,  // rate generator
    mode_square = 3'd3   // square wave
  } timer_mode_e;

  typedef enum logic [1:0] {
    rw_latch   = 2'd0,  // counter latch command
    rw_lsb     = 2'd1,
    rw_msb     = 2'd2,
    rw_lsb_msb = 2'd3
  } rw_mode_e;

  // system timer tick, about 55 ms
  localparam timer_mode_e          cnt0_reset_mode   = mode_square;
  localparam logic [count_w-1:0]   cnt0_reset_reload = 16'hFFFF;
  localparam rw_mode_e             cnt0_reset_rw     = rw_lsb_msb;
  // dram refresh request, about 15 us
  localparam timer_mode_e          cnt1_reset_mode   = mode_rate;
  localparam logic [count_w-1:0]   cnt1_reset_reload = 16'h0012;
  localparam rw_mode_e             cnt1_reset_rw     = rw_lsb;
  // speaker tone, about 1 kHz
  localparam timer_mode_e          cnt2_reset_mode   = mode_square;
  localparam logic [count_w-1:0]   cnt2_reset_reload = 16'h04A9;
  localparam rw_mode_e             cnt2_reset_rw     = rw_lsb_msb;

  // reset defaults picked by counter index
  function automatic timer_mode_e reset_mode(int idx);
    return (idx == 0) ? cnt0_reset_mode : (idx == 1) ? cnt1_reset_mode : cnt2_reset_mode;
  endfunction

  function automatic logic [count_w-1:0] reset_reload(int idx);
    return (idx == 0) ? cnt0_reset_reload : (idx == 1) ? cnt1_reset_reload : cnt2_reset_reload;
  endfunction

  function automatic rw_mode_e reset_rw(int idx);
    return (idx == 0) ? cnt0_reset_rw : (idx == 1) ? cnt1_reset_rw : cnt2_reset_rw;
  endfunction

endpackage

// ==== src/timer_reg_if.sv ====
interface timer_reg_if;
  import timer_pkg::*;

  logic                         wr_ctrl;  // control word write, one cycle
  logic [num_counters-1:0]      wr_data;  // data write per counter
  logic [num_counters-1:0]      rd_data;  // data read per counter
  logic [7:0]                   wdata;    // byte taken from the selected lane
  logic [num_counters-1:0][7:0] rdata;    // read byte of each counter

  // bus side
  modport slave_mp (
    output wr_ctrl,
    output wr_data,
    output rd_data,
    output wdata,
    input  rdata
  );

  // counter side, each counter drives its own rdata slot
  modport counter_mp (
    input  wr_ctrl,
    input  wr_data,
    input  rd_data,
    input  wdata,
    output rdata
  );

endinterface

// ==== src/timer_wb_slave.sv ====
module timer_wb_slave (
  input  logic        wb_clk_i,
  input  logic        arst_n_i,
  input  logic        wb_adr_i,
  input  logic [1:0]  wb_sel_i,
  input  logic [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  input  logic        wb_stb_i,
  input  logic        wb_cyc_i,
  input  logic        wb_we_i,
  output logic        wb_ack_o,
  output logic        wb_tgc_o,  // interrupt pulse
  input  logic        out0_i,    // counter 0 output
  timer_reg_if.slave_mp regs
);
  import timer_pkg::*;

  logic [reg_sel_w-1:0] reg_sel;
  logic                 lane_ok;
  logic                 wr_cyc;
  logic                 rd_cyc;
  logic [7:0]           rd_byte;
  logic                 out0_q;

  // classic cycle, never stalls
  assign wb_ack_o = wb_stb_i & wb_cyc_i;

  assign reg_sel = {wb_adr_i, wb_sel_i[1]};  // 0..2 counters, 3 control
  assign lane_ok = wb_sel_i[1] ^ wb_sel_i[0];  // exactly one byte lane

  assign wr_cyc = wb_ack_o & wb_we_i & lane_ok;
  assign rd_cyc = wb_ack_o & ~wb_we_i & lane_ok;

  assign regs.wr_ctrl = wr_cyc && (reg_sel == reg_sel_ctrl);
  assign regs.wdata   = wb_sel_i[1] ? wb_dat_i[15:8] : wb_dat_i[7:0];

  // select code equals counter index
  always_comb
  begin
    for (int i = 0; i < num_counters; i++)
    begin
      regs.wr_data[i] = wr_cyc && (reg_sel == reg_sel_w'(i));
      regs.rd_data[i] = rd_cyc && (reg_sel == reg_sel_w'(i));
    end
  end

  always_comb
  begin
    rd_byte = 8'h00;  // control address reads zero
    for (int i = 0; i < num_counters; i++)
    begin
      if (reg_sel == reg_sel_w'(i))
        rd_byte = regs.rdata[i];
    end
  end

  // byte back in its own lane, other lane zero
  assign wb_dat_o = wb_sel_i[1] ? {rd_byte, 8'h00} : {8'h00, rd_byte};

  // one cycle pulse on rising edge of counter 0 output
  always_ff @(posedge wb_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      out0_q   <= 1'b1;  // counter output resets high
      wb_tgc_o <= 1'b0;
    end
    else
    begin
      out0_q   <= out0_i;
      wb_tgc_o <= out0_i & ~out0_q;
    end
  end

endmodule

// ==== src/timer_tclk_sync.sv ====
module timer_tclk_sync (
  input  logic wb_clk_i,
  input  logic arst_n_i,
  input  logic tclk_i,      // slow asynchronous timer clock
  output logic tclk_edge_o  // one wb_clk_i cycle per rising edge
);

  logic tclk_meta;  // first stage, may go metastable
  logic tclk_sync;
  logic tclk_prev;  // last sampled level

  // tclk_i must hold each level for at least 3 wb_clk_i cycles
  always_ff @(posedge wb_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      tclk_meta <= 1'b0;
      tclk_sync <= 1'b0;
      tclk_prev <= 1'b0;
    end
    else
    begin
      tclk_meta <= tclk_i;
      tclk_sync <= tclk_meta;
      tclk_prev <= tclk_sync;
    end
  end

  // counters act on the third wb_clk_i edge after tclk_i rises
  assign tclk_edge_o = tclk_sync & ~tclk_prev;

endmodule

// ==== src/timer_counter.sv ====
module timer_counter #(
  parameter int cnt_index = 0  // matched against the select field
) (
  input  logic wb_clk_i,
  input  logic arst_n_i,
  input  logic tclk_edge_i,  // synchronized timer clock edge
  input  logic gate_i,
  output logic out_o,
  timer_reg_if.counter_mp regs
);
  import timer_pkg::*;

  timer_mode_e        mode_q;
  rw_mode_e           rw_q;
  logic [count_w-1:0] reload_q;       // count register written by the cpu
  logic [count_w-1:0] count_q;        // counting element
  logic [count_w-1:0] latch_q;        // output latch
  logic [count_w-1:0] even_reload;
  logic [count_w-1:0] rd_src;
  logic               load_pend_q;
  logic               out_q;
  logic               latch_armed_q;
  logic               wr_msb_q;       // next write goes to msb
  logic               rd_msb_q;       // next read returns msb
  logic               ctrl_hit;
  logic               latch_cmd;
  logic               mode_ok;
  logic               wr_hit;
  logic               rd_hit;
  logic               reload_done;
  logic               rd_last;
  logic               tick;
  logic [2:0]         cw_mode;
  rw_mode_e           cw_rw;
  logic [7:0]         rd_byte;

  // control word fields
  assign cw_rw   = rw_mode_e'(regs.wdata[cw_rw_msb -: 2]);
  assign cw_mode = regs.wdata[cw_mode_msb -: 3];

  assign ctrl_hit  = regs.wr_ctrl &&
                     (regs.wdata[cw_sel_msb -: ctrl_sel_w] == ctrl_sel_w'(cnt_index));
  assign latch_cmd = ctrl_hit && (cw_rw == rw_latch);
  assign mode_ok   = (cw_mode == mode_rate) || (cw_mode == mode_square);  // others ignored

  assign wr_hit = regs.wr_data[cnt_index];
  assign rd_hit = regs.rd_data[cnt_index];
  assign tick   = tclk_edge_i & gate_i;

  // a complete count has been written
  always_comb
  begin
    case (rw_q)
      rw_lsb, rw_msb: reload_done = wr_hit;
      rw_lsb_msb:     reload_done = wr_hit & wr_msb_q;
      default:        reload_done = 1'b0;
    endcase
  end

  // last byte of a read sequence
  always_comb
  begin
    case (rw_q)
      rw_lsb_msb: rd_last = rd_msb_q;
      default:    rd_last = 1'b1;
    endcase
  end

  assign rd_src = latch_armed_q ? latch_q : count_q;  // latched value wins

  always_comb
  begin
    case (rw_q)
      rw_msb:     rd_byte = rd_src[count_w-1 -: 8];
      rw_lsb_msb: rd_byte = rd_msb_q ? rd_src[count_w-1 -: 8] : rd_src[7:0];
      default:    rd_byte = rd_src[7:0];
    endcase
  end

  assign regs.rdata[cnt_index] = rd_byte;

  // mode, access, count register and byte toggles
  always_ff @(posedge wb_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      mode_q        <= reset_mode(cnt_index);
      rw_q          <= reset_rw(cnt_index);
      reload_q      <= reset_reload(cnt_index);
      wr_msb_q      <= 1'b0;
      rd_msb_q      <= 1'b0;
      latch_armed_q <= 1'b0;
    end
    else
    begin
      if (latch_cmd && !latch_armed_q)  // repeat latch is ignored
      begin
        latch_armed_q <= 1'b1;
        rd_msb_q      <= 1'b0;
      end
      else if (ctrl_hit && !latch_cmd && mode_ok)
      begin
        mode_q        <= timer_mode_e'(cw_mode);
        rw_q          <= cw_rw;
        wr_msb_q      <= 1'b0;
        rd_msb_q      <= 1'b0;
        latch_armed_q <= 1'b0;
      end

      if (wr_hit)
      begin
        case (rw_q)
          rw_lsb: reload_q <= {8'h00, regs.wdata};  // msb cleared
          rw_msb: reload_q <= {regs.wdata, 8'h00};
          rw_lsb_msb:
          begin
            if (wr_msb_q)
              reload_q[count_w-1 -: 8] <= regs.wdata;
            else
              reload_q[7:0] <= regs.wdata;
            wr_msb_q <= ~wr_msb_q;
          end
          default: ;
        endcase
      end

      if (rd_hit)
      begin
        if (rw_q == rw_lsb_msb)
          rd_msb_q <= ~rd_msb_q;
        if (rd_last)
          latch_armed_q <= 1'b0;  // latch released after last byte
      end
    end
  end

  // snapshot of the count for read-back
  always_ff @(posedge wb_clk_i)
  begin
    if (latch_cmd && !latch_armed_q)
      latch_q <= count_q;
  end

  // low phase of an odd mode 3 count is one period shorter
  assign even_reload = {reload_q[count_w-1:1], 1'b0};

  always_ff @(posedge wb_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      count_q     <= '0;
      load_pend_q <= 1'b1;  // reset default loads on first edge
      out_q       <= 1'b1;
    end
    else
    begin
      if (!gate_i)
      begin
        out_q       <= 1'b1;  // gate low holds output high
        load_pend_q <= 1'b1;  // restart from reload when gate returns
      end
      else if (tick)
      begin
        if (load_pend_q)
        begin
          count_q     <= reload_q;
          load_pend_q <= 1'b0;
          out_q       <= 1'b1;
        end
        else if (mode_q == mode_rate)
        begin
          if (count_q == 16'd1)
          begin
            count_q <= reload_q;  // end of the low period
            out_q   <= 1'b1;
          end
          else
          begin
            count_q <= count_q - 16'd1;
            out_q   <= (count_q != 16'd2);  // low while count is 1
          end
        end
        else
        begin
          if ((count_q == 16'd1) || (count_q == 16'd2))
          begin
            out_q   <= ~out_q;
            count_q <= out_q ? even_reload : reload_q;  // high phase gets the odd extra
          end
          else
            count_q <= count_q - 16'd2;
        end
      end

      if (reload_done)
        load_pend_q <= 1'b1;  // new count wins over a load in the same cycle
    end
  end

  assign out_o = out_q;

endmodule

// ==== src/timer.sv ====
module timer (
  input  logic        wb_clk_i,
  input  logic        arst_n_i,
  input  logic        wb_adr_i,
  input  logic [1:0]  wb_sel_i,
  input  logic [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  input  logic        wb_stb_i,
  input  logic        wb_cyc_i,
  input  logic        wb_we_i,
  output logic        wb_ack_o,
  output logic        wb_tgc_o,  // timer interrupt
  input  logic        tclk_i,    // shared counter clock
  input  logic        gate2_i,   // speaker gate
  output logic        out1_o,    // refresh request
  output logic        out2_o     // speaker
);

  logic tclk_edge;
  logic out0;  // counter 0, source of the interrupt

  timer_reg_if regs_if ();

  timer_wb_slave u_slave (
    .wb_clk_i (wb_clk_i),
    .arst_n_i (arst_n_i),
    .wb_adr_i (wb_adr_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_stb_i (wb_stb_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_we_i  (wb_we_i),
    .wb_ack_o (wb_ack_o),
    .wb_tgc_o (wb_tgc_o),
    .out0_i   (out0),
    .regs     (regs_if.slave_mp)
  );

  timer_tclk_sync u_sync (
    .wb_clk_i    (wb_clk_i),
    .arst_n_i    (arst_n_i),
    .tclk_i      (tclk_i),
    .tclk_edge_o (tclk_edge)
  );

  // counters 0 and 1 always run
  timer_counter #(.cnt_index(0)) u_cnt0 (
    .wb_clk_i    (wb_clk_i),
    .arst_n_i    (arst_n_i),
    .tclk_edge_i (tclk_edge),
    .gate_i      (1'b1),
    .out_o       (out0),
    .regs        (regs_if.counter_mp)
  );

  timer_counter #(.cnt_index(1)) u_cnt1 (
    .wb_clk_i    (wb_clk_i),
    .arst_n_i    (arst_n_i),
    .tclk_edge_i (tclk_edge),
    .gate_i      (1'b1),
    .out_o       (out1_o),
    .regs        (regs_if.counter_mp)
  );

  timer_counter #(.cnt_index(2)) u_cnt2 (
    .wb_clk_i    (wb_clk_i),
    .arst_n_i    (arst_n_i),
    .tclk_edge_i (tclk_edge),
    .gate_i      (gate2_i),
    .out_o       (out2_o),
    .regs        (regs_if.counter_mp)
  );

endmodule

// ==== verif/timer_asserts.sv ====
module timer_asserts (
  input logic        wb_clk_i,
  input logic        arst_n_i,
  input logic        wb_adr_i,
  input logic [1:0]  wb_sel_i,
  input logic [15:0] wb_dat_i,
  input logic        wb_stb_i,
  input logic        wb_cyc_i,
  input logic        wb_we_i,
  input logic        wb_ack_o,
  input logic        wb_tgc_o,
  input logic        tclk_i,
  input logic        gate2_i,
  input logic        out1_o,
  input logic        out2_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int          fail_cnt = 0;  // failed assertions so far
  logic        wr_cyc;
  logic [1:0]  reg_code;      // {adr, sel[1]}
  logic [7:0]  wr_byte;
  logic        tclk_q;
  logic        tclk_rise;
  logic        out2_q;
  logic        chg2;          // out2_o just changed
  logic [2:0]  mode2;
  logic [15:0] n2;            // expected reload of counter 2
  logic [15:0] n0;            // expected reload of counter 0
  logic        msb2;          // next data byte is the msb
  logic        msb0;
  logic [15:0] len2;          // tclk periods in the current out2 phase
  logic [15:0] len0;          // tclk periods since the last interrupt
  logic [1:0]  skip2;         // phases still settling after a change
  logic [1:0]  skip0;
  logic [15:0] hi2;
  logic [15:0] lo2;

  assign wr_cyc    = wb_stb_i & wb_cyc_i & wb_we_i;
  assign reg_code  = {wb_adr_i, wb_sel_i[1]};
  assign wr_byte   = wb_sel_i[1] ? wb_dat_i[15:8] : wb_dat_i[7:0];
  assign tclk_rise = tclk_i & ~tclk_q;
  assign chg2      = out2_o != out2_q;

  // phase lengths of the 8254 modes
  always_comb
  begin
    if (mode2 == 3'd2)
    begin
      hi2 = n2 - 16'd1;  // rate: low for one period only
      lo2 = 16'd1;
    end
    else
    begin
      hi2 = (n2 + 16'd1) >> 1;  // square: odd extra goes high
      lo2 = n2 >> 1;
    end
  end

  always_ff @(posedge wb_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      tclk_q <= 1'b0;
      out2_q <= 1'b1;
      mode2  <= 3'd3;
      n2     <= 16'h04A9;  // speaker default
      n0     <= 16'hFFFF;  // system tick default
      msb2   <= 1'b0;
      msb0   <= 1'b0;
      len2   <= '0;
      len0   <= '0;
      skip2  <= 2'd3;
      skip0  <= 2'd2;
    end
    else
    begin
      tclk_q <= tclk_i;
      out2_q <= out2_o;

      if (chg2)
      begin
        len2 <= '0;
        if (skip2 != 2'd0)
          skip2 <= skip2 - 2'd1;
      end
      else if (tclk_rise)
        len2 <= len2 + 16'd1;

      if (wb_tgc_o)
      begin
        len0 <= '0;
        if (skip0 != 2'd0)
          skip0 <= skip0 - 2'd1;
      end
      else if (tclk_rise)
        len0 <= len0 + 16'd1;

      // control word for counter 2, modes 2 and 3 only
      if (wr_cyc && (reg_code == 2'd3) && (wr_byte[7:6] == 2'd2) && (wr_byte[5:4] != 2'd0) &&
          ((wr_byte[3:1] == 3'd2) || (wr_byte[3:1] == 3'd3)))
      begin
        mode2 <= wr_byte[3:1];
        msb2  <= 1'b0;
        skip2 <= 2'd3;
      end
      if (wr_cyc && (reg_code == 2'd2))  // lsb then msb
      begin
        if (msb2)
          n2[15:8] <= wr_byte;
        else
          n2[7:0] <= wr_byte;
        msb2  <= ~msb2;
        skip2 <= 2'd3;
      end

      if (wr_cyc && (reg_code == 2'd3) && (wr_byte[7:6] == 2'd0) && (wr_byte[5:4] != 2'd0))
      begin
        msb0  <= 1'b0;
        skip0 <= 2'd2;
      end
      if (wr_cyc && (reg_code == 2'd0))
      begin
        if (msb0)
          n0[15:8] <= wr_byte;
        else
          n0[7:0] <= wr_byte;
        msb0  <= ~msb0;
        skip0 <= 2'd2;
      end

      if (!gate2_i)
        skip2 <= 2'd3;  // restarts from reload when gate returns
    end
  end

  a_ack: assert property (@(posedge wb_clk_i) wb_ack_o == (wb_stb_i && wb_cyc_i))
  else
  begin
    $error("Mismatch wb_ack_o: got 0x%h expected 0x%h",
           $sampled(wb_ack_o), $sampled(wb_stb_i && wb_cyc_i));
    fail_cnt++;
  end

  a_reset: assert property (@(posedge wb_clk_i) $rose(arst_n_i) |-> !wb_tgc_o && out1_o && out2_o)
  else
  begin
    $error("Mismatch {wb_tgc_o, out1_o, out2_o} after reset: got 0x%h expected 0x3",
           $sampled({wb_tgc_o, out1_o, out2_o}));
    fail_cnt++;
  end

  a_gate: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i) !gate2_i |=> out2_o)
  else
  begin
    $error("Mismatch out2_o with gate2_i low: got 0x%h expected 0x1", $sampled(out2_o));
    fail_cnt++;
  end

  a_out2_phase: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
    chg2 && (skip2 == 2'd0) |-> len2 == (out2_q ? hi2 : lo2))
  else
  begin
    $error("Mismatch out2_o phase length: got 0x%h expected 0x%h",
           $sampled(len2), $sampled(out2_q) ? $sampled(hi2) : $sampled(lo2));
    fail_cnt++;
  end

  a_tgc_pulse: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
    wb_tgc_o |=> !wb_tgc_o)
  else
  begin
    $error("wb_tgc_o held high for more than one cycle");
    fail_cnt++;
  end

  a_tgc_period: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
    wb_tgc_o && (skip0 == 2'd0) |-> len0 == n0)
  else
  begin
    $error("Mismatch wb_tgc_o period in tclk periods: got 0x%h expected 0x%h",
           $sampled(len0), $sampled(n0));
    fail_cnt++;
  end

endmodule

bind timer timer_asserts u_asserts (
  .wb_clk_i (wb_clk_i),
  .arst_n_i (arst_n_i),
  .wb_adr_i (wb_adr_i),
  .wb_sel_i (wb_sel_i),
  .wb_dat_i (wb_dat_i),
  .wb_stb_i (wb_stb_i),
  .wb_cyc_i (wb_cyc_i),
  .wb_we_i  (wb_we_i),
  .wb_ack_o (wb_ack_o),
  .wb_tgc_o (wb_tgc_o),
  .tclk_i   (tclk_i),
  .gate2_i  (gate2_i),
  .out1_o   (out1_o),
  .out2_o   (out2_o)
);

// ==== verif/timer_tb.sv ====
module timer_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int tclk_half   = 8;   // wb_clk_i cycles per tclk level
  localparam int ack_limit   = 8;
  localparam int max_n       = 40;  // largest reload
  // tclk periods over all tests
  localparam int run_periods = 2 + 3 * (3 * max_n + 4) + 20 + (2 * max_n + 4) + max_n + 42;
  localparam int timeout_cycles = 2 * tclk_half * run_periods + 1000;  // bus cycles, margin

  logic        wb_clk_i = 1'b0;
  logic        arst_n_i;
  logic        wb_adr_i;
  logic [1:0]  wb_sel_i;
  logic [15:0] wb_dat_i;
  logic [15:0] wb_dat_o;
  logic        wb_stb_i;
  logic        wb_cyc_i;
  logic        wb_we_i;
  logic        wb_ack_o;
  logic        wb_tgc_o;
  logic        tclk_i;
  logic        gate2_i;
  logic        out1_o;
  logic        out2_o;
  logic [31:0] lfsr_q;
  logic        tgc_count_en = 1'b0;
  int          tb_errs      = 0;
  int          tgc_pulses   = 0;
  int          cycle_cnt    = 0;

  timer dut0 (.*);

  always #2 wb_clk_i = ~wb_clk_i;  // 4 ns period

  always @(posedge wb_clk_i)
  begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles)
    begin
      $display("timeout: run still going after %0d clock cycles", cycle_cnt);
      $display("Errors found");
      $finish;
    end
  end

  always @(negedge wb_clk_i)
  begin
    if (tgc_count_en && wb_tgc_o)
      tgc_pulses++;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int nbits, output int val);
    val = 0;
    for (int i = 0; i < nbits; i++)
    begin
      val    = (val << 1) | int'(lfsr_q[0]);
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic rand_reload(output int n);
    int v;
    take_bits(6, v);
    n = 3 + v % 38;  // 3..40
  endtask

  // n rising edges on tclk_i, ends low
  task automatic tclk_pulses(input int n);
    for (int i = 0; i < n; i++)
    begin
      @(negedge wb_clk_i);
      tclk_i = 1'b1;
      repeat (tclk_half) @(negedge wb_clk_i);
      tclk_i = 1'b0;
      repeat (tclk_half - 1) @(negedge wb_clk_i);
    end
  endtask

  // cyc alone, then stb alone, no acknowledge either time
  task automatic drive_stb_cyc_apart();
    @(negedge wb_clk_i);
    wb_cyc_i = 1'b1;
    @(negedge wb_clk_i);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b1;
    @(negedge wb_clk_i);
    wb_stb_i = 1'b0;
  endtask

  // single classic cycle, sampled mid-cycle
  task automatic bus_cycle(input logic we, input logic adr, input logic [1:0] sel,
                           input logic [15:0] wdat, output logic [15:0] rdat);
    int waited;
    waited = 0;
    @(negedge wb_clk_i);
    wb_adr_i = adr;
    wb_sel_i = sel;
    wb_dat_i = wdat;
    wb_we_i  = we;
    wb_stb_i = 1'b1;
    wb_cyc_i = 1'b1;
    #1;
    while (!wb_ack_o && (waited < ack_limit))
    begin
      @(negedge wb_clk_i);
      #1;
      waited++;
    end
    if (!wb_ack_o)
    begin
      tb_errs++;
      $display("bus error: no acknowledge after %0d cycles", waited);
    end
    rdat = wb_dat_o;
    @(posedge wb_clk_i);  // cycle ends here
    @(negedge wb_clk_i);
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  // reg_idx is {adr, sel[1]}, 3 is the control word
  task automatic write_byte(input int reg_idx, input logic [7:0] data);
    logic [15:0] unused_rd;
    bus_cycle(1'b1, reg_idx[1], reg_idx[0] ? 2'b10 : 2'b01,
              reg_idx[0] ? {data, 8'h00} : {8'h00, data}, unused_rd);
  endtask

  task automatic read_check(input int reg_idx, input logic [7:0] exp_byte);
    logic [15:0] got;
    logic [15:0] exp;
    exp = reg_idx[0] ? {exp_byte, 8'h00} : {8'h00, exp_byte};  // other lane zero
    bus_cycle(1'b0, reg_idx[1], reg_idx[0] ? 2'b10 : 2'b01, 16'h0000, got);
    if (got !== exp)
    begin
      tb_errs++;
      $display("Mismatch wb_dat_o: got 0x%h expected 0x%h", got, exp);
    end
  endtask

  // control word: select, lsb then msb, mode, binary
  task automatic program_count(input int idx, input logic [2:0] mode, input logic [15:0] n);
    write_byte(3, {idx[1:0], 2'b11, mode, 1'b0});
    write_byte(idx, n[7:0]);
    write_byte(idx, n[15:8]);
  endtask

  initial
  begin
    int          n;
    int          v;
    int          k;
    logic [15:0] cnt_exp;
    arst_n_i = 1'b0;
    wb_adr_i = 1'b0;
    wb_sel_i = 2'b00;
    wb_dat_i = 16'h0000;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_we_i  = 1'b0;
    tclk_i   = 1'b0;
    gate2_i  = 1'b1;
    lfsr_q   = 32'h21d5;
    repeat (4) @(negedge wb_clk_i);
    arst_n_i = 1'b1;
    drive_stb_cyc_apart();  // ack needs both
    tclk_pulses(2);  // reset defaults load

    rand_reload(n);  // counter 2 rate generator
    program_count(2, 3'd2, 16'(n));
    tclk_pulses(3 * n + 4);

    rand_reload(n);  // square wave, odd count
    if (n % 2 == 0)
      n = n - 1;
    program_count(2, 3'd3, 16'(n));
    tclk_pulses(3 * n + 4);
    rand_reload(n);  // and even count
    if (n % 2 == 1)
      n = n + 1;
    program_count(2, 3'd3, 16'(n));
    tclk_pulses(3 * n + 4);

    @(negedge wb_clk_i);
    gate2_i = 1'b0;  // speaker held off
    tclk_pulses(20);
    gate2_i = 1'b1;
    tclk_pulses(2 * n + 4);

    rand_reload(n);  // counter 1 latch read-back
    take_bits(6, v);
    k = 1 + v % (n - 1);
    program_count(1, 3'd2, 16'(n));
    tclk_pulses(k);
    write_byte(3, 8'h40);  // latch counter 1
    cnt_exp = 16'(n - (k - 1));  // first edge only loads
    read_check(1, cnt_exp[7:0]);
    read_check(1, cnt_exp[15:8]);

    take_bits(3, v);  // counter 0 interrupt, small reload
    n = 3 + v;
    tgc_count_en = 1'b1;
    program_count(0, 3'd3, 16'(n));
    tclk_pulses(4 * n + 2);  // four full periods
    @(negedge wb_clk_i);
    tgc_count_en = 1'b0;
    if (tgc_pulses != 4)
    begin
      tb_errs++;
      $display("Mismatch wb_tgc_o pulses: got 0x%h expected 0x%h", tgc_pulses, 4);
    end

    repeat (2) @(negedge wb_clk_i);
    $display("error counts: testbench %0d, assertions %0d", tb_errs, dut0.u_asserts.fail_cnt);
    if ((tb_errs == 0) && (dut0.u_asserts.fail_cnt == 0))
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// ==== files.f ====
src/timer_pkg.sv
src/timer_reg_if.sv
src/timer_wb_slave.sv
src/timer_tclk_sync.sv
src/timer_counter.sv
src/timer.sv
verif/timer_asserts.sv
verif/timer_tb.sv

// ==== Makefile ====
TOP = timer_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps -f files.f --top-module $(TOP) -o $(TOP)
	out=$$(./obj_dir/$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir
